// ==== hw/sched_defines.svh ====
`ifndef SCHED_DEFINES_SVH
`define SCHED_DEFINES_SVH

// Sizes of the scheduler
`define SCHED_CORE_COUNT       4
`define SCHED_IF_COUNT         2
`define SCHED_SLOT_COUNT       8

// Control word is a type nibble above a 32-bit payload
`define SCHED_CTRL_WIDTH       36
`define SCHED_MSG_TYPE_WIDTH   4

`define SCHED_HASH_WIDTH       32
`define SCHED_HASH_SEL_OFFSET  0
`define SCHED_TAG_WIDTH        5

// FIFO depths
`define SCHED_DONE_DEPTH       8
`define SCHED_DESC_DEPTH       4

`endif

// ==== hw/sched_pkg.sv ====
`include "sched_defines.svh"

package sched_pkg;

  typedef logic [$clog2(`SCHED_CORE_COUNT)-1:0]   core_id_t;
  // Holds a slot number or a count up to SLOT_COUNT
  typedef logic [$clog2(`SCHED_SLOT_COUNT+1)-1:0] slot_t;
  typedef logic [$clog2(`SCHED_IF_COUNT)-1:0]     if_idx_t;
  typedef logic [`SCHED_HASH_WIDTH-1:0]           hash_t;

  typedef logic [`SCHED_CTRL_WIDTH-`SCHED_MSG_TYPE_WIDTH-1:0] desc_t;
  typedef logic [`SCHED_CTRL_WIDTH-1:0]                       ctrl_word_t;

  // Core number above the zero-extended slot field
  typedef logic [$clog2(`SCHED_CORE_COUNT)+`SCHED_TAG_WIDTH-1:0] id_tag_t;

  // On the output side type 0 means send out
  typedef enum logic [`SCHED_MSG_TYPE_WIDTH-1:0] {
    MSG_SLOT_RETURN = 0,
    MSG_PKT_DONE    = 1,
    MSG_SLOT_INIT   = 3
  } msg_type_e;

endpackage

// ==== hw/sched_if.sv ====
`timescale 1ns/100ps
`include "sched_defines.svh"

// Slot commands decoded from the control messages
interface slot_cmd_if;
  import sched_pkg::*;

  core_id_t core;
  slot_t    slot;
  logic     enq;
  logic     init;

  modport src (output core, slot, enq, init);
  modport dst (input core, slot, enq, init);
endinterface

// Free slot status per core and the pop request
interface slot_alloc_if;
  import sched_pkg::*;

  logic [`SCHED_CORE_COUNT-1:0]  avail;
  slot_t [`SCHED_CORE_COUNT-1:0] head;
  logic                          pop;
  core_id_t                      pop_core;

  modport alloc (
    input  avail, head,
    output pop, pop_core
  );
  modport pool (
    output avail, head,
    input  pop, pop_core
  );
endinterface

// ==== hw/sync_fifo.sv ====
`timescale 1ns/100ps

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             rst_r,
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output logic [WIDTH-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   fill;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign in_ready  = (fill != (PTR_W+1)'(DEPTH));
  assign out_valid = (fill != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      fill <= fill + push - pop;
    end
  end

endmodule

// ==== hw/slot_keeper.sv ====
`timescale 1ns/100ps
`include "sched_defines.svh"

module slot_keeper (
  input  logic             clk,
  input  logic             rst_r,
  input  logic             init,
  input  logic             enq,
  input  sched_pkg::slot_t slot_in,
  input  logic             pop,
  output sched_pkg::slot_t head,
  output logic             avail,
  output sched_pkg::slot_t count
);
  import sched_pkg::*;

  localparam int DEPTH = `SCHED_SLOT_COUNT;
  localparam int PTR_W = $clog2(DEPTH);

  slot_t            list_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  slot_t            init_n;
  logic             full;
  logic             do_enq;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // An init asking for more slots than exist takes them all
  assign init_n = (slot_in > slot_t'(DEPTH)) ? slot_t'(DEPTH) : slot_in;
  assign full   = (count == slot_t'(DEPTH));
  assign avail  = (count != '0);
  assign head   = list_q[rd_ptr];
  assign do_enq = enq && !full;
  assign do_pop = pop && avail;

  always_ff @(posedge clk) begin
    if (init) begin
      for (int i = 0; i < DEPTH; i++) begin
        list_q[i] <= slot_t'(i);
      end
    end else if (do_enq) begin
      list_q[wr_ptr] <= slot_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (init) begin
      rd_ptr <= '0;
      wr_ptr <= init_n[PTR_W-1:0];
      count  <= init_n;
    end else begin
      if (do_enq) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + do_enq - do_pop;
    end
  end

endmodule

// ==== hw/slot_pool.sv ====
`timescale 1ns/100ps
`include "sched_defines.svh"

module slot_pool (
  input  logic                clk,
  input  logic                rst_r,
  slot_cmd_if.dst             cmd,
  slot_alloc_if.pool          alloc,
  input  sched_pkg::core_id_t stat_read_core,
  output sched_pkg::slot_t    slot_count
);
  import sched_pkg::*;

  localparam int CORES = `SCHED_CORE_COUNT;

  slot_t [CORES-1:0] counts;
  slot_t [CORES-1:0] heads;
  logic [CORES-1:0]  avails;
  core_id_t          stat_core_r;

  for (genvar c = 0; c < CORES; c++) begin : g_keeper
    slot_keeper i_slot_keeper (
      .clk     (clk),
      .rst_r   (rst_r),
      .init    (cmd.init && (cmd.core == core_id_t'(c))),
      .enq     (cmd.enq && (cmd.core == core_id_t'(c))),
      .slot_in (cmd.slot),
      .pop     (alloc.pop && (alloc.pop_core == core_id_t'(c))),
      .head    (heads[c]),
      .avail   (avails[c]),
      .count   (counts[c])
    );
  end

  assign alloc.head  = heads;
  assign alloc.avail = avails;

  // Readback goes through two registers
  always_ff @(posedge clk) begin
    if (rst_r) begin
      stat_core_r <= '0;
      slot_count  <= '0;
    end else begin
      stat_core_r <= stat_read_core;
      slot_count  <= counts[stat_core_r];
    end
  end

endmodule

// ==== hw/ctrl_msg_decode.sv ====
`timescale 1ns/100ps
`include "sched_defines.svh"

module ctrl_msg_decode (
  input  logic                  clk,
  input  logic                  rst_r,
  input  sched_pkg::ctrl_word_t ctrl_s_data,
  input  sched_pkg::core_id_t   ctrl_s_user,
  input  logic                  ctrl_s_valid,
  output logic                  ctrl_s_ready,
  slot_cmd_if.src               cmd,
  output sched_pkg::desc_t      done_desc,
  output sched_pkg::core_id_t   done_src,
  output logic                  done_valid,
  input  logic                  done_ready
);
  import sched_pkg::*;

  localparam int TYPE_W   = `SCHED_MSG_TYPE_WIDTH;
  localparam int SLOT_LSB = 16;

  ctrl_word_t in_data_r;
  core_id_t   in_user_r;
  logic       in_valid_r;
  msg_type_e  msg_type;

  assign msg_type     = msg_type_e'(in_data_r[`SCHED_CTRL_WIDTH-1 -: TYPE_W]);
  assign done_desc    = in_data_r[$bits(desc_t)-1:0];
  assign done_src     = in_user_r;
  assign done_valid   = in_valid_r && (msg_type == MSG_PKT_DONE);
  // Only a stuck packet-done word blocks the input
  assign ctrl_s_ready = !(done_valid && !done_ready);

  always_ff @(posedge clk) begin
    if (rst_r) begin
      in_valid_r <= 1'b0;
      cmd.enq    <= 1'b0;
      cmd.init   <= 1'b0;
    end else begin
      if (ctrl_s_ready) begin
        in_valid_r <= ctrl_s_valid;
      end
      cmd.enq  <= in_valid_r && (msg_type == MSG_SLOT_RETURN);
      cmd.init <= in_valid_r && (msg_type == MSG_SLOT_INIT);
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl_s_valid && ctrl_s_ready) begin
      in_data_r <= ctrl_s_data;
      in_user_r <= ctrl_s_user;
    end
    cmd.core <= in_user_r;
    cmd.slot <= in_data_r[SLOT_LSB +: $bits(slot_t)];
  end

endmodule

// ==== hw/ctrl_out_mux.sv ====
`timescale 1ns/100ps
`include "sched_defines.svh"

module ctrl_out_mux (
  input  logic                              clk,
  input  logic                              rst_r,
  input  sched_pkg::desc_t                  done_desc,
  input  sched_pkg::core_id_t               done_src,
  input  logic                              done_valid,
  output logic                              done_ready,
  input  logic [`SCHED_MSG_TYPE_WIDTH-1:0]  host_cmd,
  input  sched_pkg::core_id_t               host_cmd_dest,
  input  sched_pkg::desc_t                  host_cmd_data,
  input  logic                              host_cmd_valid,
  output logic                              host_cmd_ready,
  output sched_pkg::ctrl_word_t             ctrl_m_data,
  output sched_pkg::core_id_t               ctrl_m_dest,
  output logic                              ctrl_m_valid,
  input  logic                              ctrl_m_ready
);
  import sched_pkg::*;

  // Type 0 on the way out means send out
  localparam msg_type_e SEND_OUT = MSG_SLOT_RETURN;

  desc_t                            fifo_desc;
  core_id_t                         fifo_src;
  logic                             fifo_valid;
  logic                             fifo_ready;
  logic [`SCHED_MSG_TYPE_WIDTH-1:0] host_cmd_r;
  core_id_t                         host_dest_r;
  desc_t                            host_data_r;
  logic                             host_valid_r;
  logic                             out_free;

  sync_fifo #(
    .WIDTH ($bits(core_id_t) + $bits(desc_t)),
    .DEPTH (`SCHED_DONE_DEPTH)
  ) i_done_fifo (
    .clk       (clk),
    .rst_r     (rst_r),
    .in_data   ({done_src, done_desc}),
    .in_valid  (done_valid),
    .in_ready  (done_ready),
    .out_data  ({fifo_src, fifo_desc}),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready)
  );

  assign host_cmd_ready = !host_valid_r;
  assign out_free       = !ctrl_m_valid || ctrl_m_ready;
  // Host command always goes first
  assign fifo_ready     = out_free && !host_valid_r;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      host_valid_r <= 1'b0;
      ctrl_m_valid <= 1'b0;
    end else begin
      if (host_cmd_valid && !host_valid_r) begin
        host_valid_r <= 1'b1;
      end else if (out_free) begin
        host_valid_r <= 1'b0;
      end
      if (out_free) begin
        ctrl_m_valid <= host_valid_r || fifo_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (host_cmd_valid && !host_valid_r) begin
      host_cmd_r  <= host_cmd;
      host_dest_r <= host_cmd_dest;
      host_data_r <= host_cmd_data;
    end
    if (out_free && host_valid_r) begin
      ctrl_m_data <= {host_cmd_r, host_data_r};
      ctrl_m_dest <= host_dest_r;
    end else if (out_free && fifo_valid) begin
      ctrl_m_data <= {SEND_OUT, fifo_desc};
      ctrl_m_dest <= fifo_src;
    end
  end

endmodule

// ==== hw/rx_desc_alloc.sv ====
`timescale 1ns/100ps
`include "sched_defines.svh"

module rx_desc_alloc (
  input  logic                                     clk,
  input  logic                                     rst_r,
  input  sched_pkg::hash_t [`SCHED_IF_COUNT-1:0]   rx_hash,
  input  logic [`SCHED_IF_COUNT-1:0]               rx_hash_valid,
  output logic [`SCHED_IF_COUNT-1:0]               rx_hash_ready,
  input  logic [`SCHED_CORE_COUNT-1:0]             income_cores,
  slot_alloc_if.alloc                              alloc,
  output sched_pkg::hash_t [`SCHED_IF_COUNT-1:0]   rx_desc_hash,
  output sched_pkg::id_tag_t [`SCHED_IF_COUNT-1:0] rx_desc_tag,
  output logic [`SCHED_IF_COUNT-1:0]               rx_desc_valid,
  input  logic [`SCHED_IF_COUNT-1:0]               rx_desc_ready
);
  import sched_pkg::*;

  localparam int IFS    = `SCHED_IF_COUNT;
  localparam int CORE_W = $bits(core_id_t);
  localparam int PAD_W  = `SCHED_TAG_WIDTH - $bits(slot_t);
  localparam int RES_W  = $bits(hash_t) + $bits(id_tag_t);

  logic [IFS-1:0]   fifo_ready;
  logic [IFS-1:0]   req;
  logic [IFS-1:0]   grant;
  if_idx_t          grant_idx;
  logic             grant_v;
  logic [IFS-1:0]   grant_r;
  if_idx_t          grant_idx_r;
  if_idx_t          last_r;
  core_id_t         core_r;
  logic             take;
  id_tag_t          tag;
  logic [RES_W-1:0] result;

  // Skip the interface granted last cycle and any with a full result FIFO
  assign req = rx_hash_valid & ~grant_r & fifo_ready;

  always_comb begin
    int unsigned cand;
    cand      = 0;
    grant     = '0;
    grant_idx = last_r;
    grant_v   = 1'b0;
    for (int k = 1; k <= IFS; k++) begin
      cand = (int'(last_r) + k) % IFS;
      if (!grant_v && req[cand]) begin
        grant[cand] = 1'b1;
        grant_idx   = if_idx_t'(cand);
        grant_v     = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      grant_r <= '0;
      last_r  <= '0;
    end else begin
      grant_r <= grant;
      if (grant_v) begin
        last_r <= grant_idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    grant_idx_r <= grant_idx;
    core_r      <= rx_hash[grant_idx][`SCHED_HASH_SEL_OFFSET +: CORE_W];
  end

  // Second cycle pops the slot, consumes the hash and pushes the result together
  assign take           = (|grant_r) && income_cores[core_r] && alloc.avail[core_r];
  assign alloc.pop      = take;
  assign alloc.pop_core = core_r;
  assign rx_hash_ready  = take ? grant_r : '0;
  assign tag            = {core_r, {PAD_W{1'b0}}, alloc.head[core_r]};
  assign result         = {rx_hash[grant_idx_r], tag};

  for (genvar i = 0; i < IFS; i++) begin : g_result
    sync_fifo #(
      .WIDTH (RES_W),
      .DEPTH (`SCHED_DESC_DEPTH)
    ) i_result_fifo (
      .clk       (clk),
      .rst_r     (rst_r),
      .in_data   (result),
      .in_valid  (take && grant_r[i]),
      .in_ready  (fifo_ready[i]),
      .out_data  ({rx_desc_hash[i], rx_desc_tag[i]}),
      .out_valid (rx_desc_valid[i]),
      .out_ready (rx_desc_ready[i])
    );
  end

endmodule

// ==== hw/sched_top.sv ====
`timescale 1ns/100ps
`include "sched_defines.svh"

module sched_top (
  input  logic                                     clk,
  input  logic                                     rst_r,
  input  sched_pkg::ctrl_word_t                    ctrl_s_data,
  input  sched_pkg::core_id_t                      ctrl_s_user,
  input  logic                                     ctrl_s_valid,
  output logic                                     ctrl_s_ready,
  output sched_pkg::ctrl_word_t                    ctrl_m_data,
  output sched_pkg::core_id_t                      ctrl_m_dest,
  output logic                                     ctrl_m_valid,
  input  logic                                     ctrl_m_ready,
  input  logic [`SCHED_MSG_TYPE_WIDTH-1:0]         host_cmd,
  input  sched_pkg::core_id_t                      host_cmd_dest,
  input  sched_pkg::desc_t                         host_cmd_data,
  input  logic                                     host_cmd_valid,
  output logic                                     host_cmd_ready,
  input  logic [`SCHED_CORE_COUNT-1:0]             income_cores,
  input  sched_pkg::hash_t [`SCHED_IF_COUNT-1:0]   rx_hash,
  input  logic [`SCHED_IF_COUNT-1:0]               rx_hash_valid,
  output logic [`SCHED_IF_COUNT-1:0]               rx_hash_ready,
  output sched_pkg::hash_t [`SCHED_IF_COUNT-1:0]   rx_desc_hash,
  output sched_pkg::id_tag_t [`SCHED_IF_COUNT-1:0] rx_desc_tag,
  output logic [`SCHED_IF_COUNT-1:0]               rx_desc_valid,
  input  logic [`SCHED_IF_COUNT-1:0]               rx_desc_ready,
  input  sched_pkg::core_id_t                      stat_read_core,
  output sched_pkg::slot_t                         slot_count
);
  import sched_pkg::*;

  desc_t    done_desc;
  core_id_t done_src;
  logic     done_valid;
  logic     done_ready;

  slot_cmd_if   slot_cmd ();
  slot_alloc_if slot_alloc ();

  ctrl_msg_decode i_ctrl_msg_decode (
    .clk          (clk),
    .rst_r        (rst_r),
    .ctrl_s_data  (ctrl_s_data),
    .ctrl_s_user  (ctrl_s_user),
    .ctrl_s_valid (ctrl_s_valid),
    .ctrl_s_ready (ctrl_s_ready),
    .cmd          (slot_cmd),
    .done_desc    (done_desc),
    .done_src     (done_src),
    .done_valid   (done_valid),
    .done_ready   (done_ready)
  );

  slot_pool i_slot_pool (
    .clk            (clk),
    .rst_r          (rst_r),
    .cmd            (slot_cmd),
    .alloc          (slot_alloc),
    .stat_read_core (stat_read_core),
    .slot_count     (slot_count)
  );

  ctrl_out_mux i_ctrl_out_mux (
    .clk            (clk),
    .rst_r          (rst_r),
    .done_desc      (done_desc),
    .done_src       (done_src),
    .done_valid     (done_valid),
    .done_ready     (done_ready),
    .host_cmd       (host_cmd),
    .host_cmd_dest  (host_cmd_dest),
    .host_cmd_data  (host_cmd_data),
    .host_cmd_valid (host_cmd_valid),
    .host_cmd_ready (host_cmd_ready),
    .ctrl_m_data    (ctrl_m_data),
    .ctrl_m_dest    (ctrl_m_dest),
    .ctrl_m_valid   (ctrl_m_valid),
    .ctrl_m_ready   (ctrl_m_ready)
  );

  rx_desc_alloc i_rx_desc_alloc (
    .clk           (clk),
    .rst_r         (rst_r),
    .rx_hash       (rx_hash),
    .rx_hash_valid (rx_hash_valid),
    .rx_hash_ready (rx_hash_ready),
    .income_cores  (income_cores),
    .alloc         (slot_alloc),
    .rx_desc_hash  (rx_desc_hash),
    .rx_desc_tag   (rx_desc_tag),
    .rx_desc_valid (rx_desc_valid),
    .rx_desc_ready (rx_desc_ready)
  );

endmodule

// ==== bench/tb_sched_top.sv ====
`timescale 1ns/100ps
`include "sched_defines.svh"

module tb_sched_top;
  import sched_pkg::*;

  localparam int CORES   = `SCHED_CORE_COUNT;
  localparam int TIMEOUT = 200;

  logic                      clk;
  logic                      rst_r;
  ctrl_word_t                ctrl_s_data;
  core_id_t                  ctrl_s_user;
  logic                      ctrl_s_valid;
  logic                      ctrl_s_ready;
  ctrl_word_t                ctrl_m_data;
  core_id_t                  ctrl_m_dest;
  logic                      ctrl_m_valid;
  logic                      ctrl_m_ready;
  logic [3:0]                host_cmd;
  core_id_t                  host_cmd_dest;
  desc_t                     host_cmd_data;
  logic                      host_cmd_valid;
  logic                      host_cmd_ready;
  logic [CORES-1:0]          income_cores;
  hash_t [1:0]               rx_hash;
  logic [1:0]                rx_hash_valid;
  logic [1:0]                rx_hash_ready;
  hash_t [1:0]               rx_desc_hash;
  id_tag_t [1:0]             rx_desc_tag;
  logic [1:0]                rx_desc_valid;
  logic [1:0]                rx_desc_ready;
  core_id_t                  stat_read_core;
  slot_t                     slot_count;

  // Reference model of the free slots and of the expected control output
  slot_t                     free_q [CORES][$];
  logic [37:0]               out_q [$];

  sched_top i_sched_top (.*);

  always #50 clk = ~clk;

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_equal(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      $display("FAIL %s: expected %0h actual %0h", name, exp, act);
      stop_run("value mismatch");
    end
  endtask

  // Output word must hold while the consumer stalls
  assert property (@(posedge clk) disable iff (rst_r)
    ctrl_m_valid && !ctrl_m_ready |=> ctrl_m_valid && $stable(ctrl_m_data) && $stable(ctrl_m_dest))
    else stop_run("control output changed while stalled");

  function automatic id_tag_t make_tag(input core_id_t c, input slot_t s);
    return (id_tag_t'(c) << `SCHED_TAG_WIDTH) | id_tag_t'(s);
  endfunction

  function automatic hash_t hash_for_core(input core_id_t c);
    return ($urandom & ~hash_t'(CORES - 1)) | hash_t'(c);
  endfunction

  task automatic send_ctrl(input core_id_t user, input ctrl_word_t data);
    int n;
    n = 0;
    @(negedge clk);
    ctrl_s_data  = data;
    ctrl_s_user  = user;
    ctrl_s_valid = 1'b1;
    #1;
    while (!ctrl_s_ready) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) stop_run("control input never became ready");
    end
    @(negedge clk);
    ctrl_s_valid = 1'b0;
  endtask

  task automatic start_hash(input int i, input hash_t h);
    @(negedge clk);
    rx_hash[i]       = h;
    rx_hash_valid[i] = 1'b1;
  endtask

  task automatic finish_hash(input int i);
    int n;
    n = 0;
    #1;
    while (!rx_hash_ready[i]) begin
      @(negedge clk);
      #1;
      n++;
      if (n > TIMEOUT) stop_run("hash request was never accepted");
    end
    @(negedge clk);
    rx_hash_valid[i] = 1'b0;
  endtask

  task automatic expect_result(input int i, input hash_t h, input id_tag_t tag);
    int n;
    n = 0;
    @(negedge clk);
    #1;
    while (!rx_desc_valid[i]) begin
      @(negedge clk);
      #1;
      n++;
      if (n > TIMEOUT) stop_run("no descriptor result arrived");
    end
    check_equal("desc_hash", 64'(h), 64'(rx_desc_hash[i]));
    check_equal("desc_tag", 64'(tag), 64'(rx_desc_tag[i]));
    rx_desc_ready[i] = 1'b1;
    @(negedge clk);
    rx_desc_ready[i] = 1'b0;
  endtask

  task automatic allocate(input int i, input core_id_t c);
    hash_t   h;
    id_tag_t tag;
    h   = hash_for_core(c);
    tag = make_tag(c, free_q[c].pop_front());
    fork
      begin
        start_hash(i, h);
        finish_hash(i);
      end
      expect_result(i, h, tag);
    join
  endtask

  task automatic check_counts(input string name);
    for (int c = 0; c < CORES; c++) begin
      @(negedge clk);
      stat_read_core = core_id_t'(c);
      repeat (4) @(negedge clk);
      check_equal(name, 64'(free_q[c].size()), 64'(slot_count));
    end
  endtask

  task automatic quiet_window(input int i, input int cycles);
    for (int k = 0; k < cycles; k++) begin
      @(negedge clk);
      #1;
      assert (!rx_desc_valid[i] && !rx_hash_ready[i])
        else stop_run("request completed while it should be held");
    end
  endtask

  task automatic send_done(input core_id_t c);
    desc_t p;
    p = $urandom;
    out_q.push_back({c, 4'd0, p});
    send_ctrl(c, {MSG_PKT_DONE, p});
  endtask

  task automatic drain_output(input string name);
    int          n;
    logic [37:0] exp;
    while (out_q.size() > 0) begin
      exp = out_q.pop_front();
      n   = 0;
      @(negedge clk);
      #1;
      while (!ctrl_m_valid) begin
        @(negedge clk);
        #1;
        n++;
        if (n > TIMEOUT) stop_run("control output message missing");
      end
      check_equal({name, "_dest"}, 64'(exp[37:36]), 64'(ctrl_m_dest));
      check_equal({name, "_data"}, 64'(exp[35:0]), 64'(ctrl_m_data));
      ctrl_m_ready = 1'b1;
      @(negedge clk);
      ctrl_m_ready = 1'b0;
    end
  endtask

  initial begin
    slot_t    cnt;
    slot_t    s;
    hash_t    h0;
    hash_t    h1;
    id_tag_t  t0;
    id_tag_t  t1;
    int       n;

    void'($urandom(51876));
    clk            = 1'b0;
    rst_r          = 1'b1;
    ctrl_s_data    = '0;
    ctrl_s_user    = '0;
    ctrl_s_valid   = 1'b0;
    ctrl_m_ready   = 1'b0;
    host_cmd       = '0;
    host_cmd_dest  = '0;
    host_cmd_data  = '0;
    host_cmd_valid = 1'b0;
    income_cores   = '1;
    rx_hash        = '0;
    rx_hash_valid  = '0;
    rx_desc_ready  = '0;
    stat_read_core = '0;
    repeat (2) @(negedge clk);
    rst_r = 1'b0;

    // Slot init with random counts
    for (int c = 0; c < CORES; c++) begin
      cnt = slot_t'($urandom_range(3, `SCHED_SLOT_COUNT));
      free_q[c].delete();
      for (int k = 0; k < int'(cnt); k++) free_q[c].push_back(slot_t'(k));
      send_ctrl(core_id_t'(c), {MSG_SLOT_INIT, desc_t'(cnt) << 16});
    end
    check_counts("init_count");

    // Both interfaces at once on different cores
    h0 = $urandom;
    h1 = hash_for_core(core_id_t'(h0) ^ 2'd1);
    t0 = make_tag(core_id_t'(h0), free_q[core_id_t'(h0)].pop_front());
    t1 = make_tag(core_id_t'(h1), free_q[core_id_t'(h1)].pop_front());
    fork
      begin
        start_hash(0, h0);
        finish_hash(0);
      end
      begin
        start_hash(1, h1);
        finish_hash(1);
      end
      expect_result(0, h0, t0);
      expect_result(1, h1, t1);
    join
    check_counts("alloc_count");

    // Disabled core holds its request
    income_cores = 4'b1011;
    h0 = hash_for_core(2'd2);
    t0 = make_tag(2'd2, free_q[2].pop_front());
    start_hash(1, h0);
    quiet_window(1, 30);
    income_cores = '1;
    fork
      finish_hash(1);
      expect_result(1, h0, t0);
    join

    // Empty pool waits for a slot return
    while (free_q[1].size() > 0) allocate(0, 2'd1);
    h0 = hash_for_core(2'd1);
    start_hash(0, h0);
    quiet_window(0, 20);
    s = slot_t'($urandom_range(0, `SCHED_SLOT_COUNT - 1));
    send_ctrl(2'd1, {MSG_SLOT_RETURN, desc_t'(s) << 16});
    fork
      finish_hash(0);
      expect_result(0, h0, make_tag(2'd1, s));
    join
    check_counts("return_count");

    // Packet done under back-pressure fills the done FIFO and keeps order
    for (int k = 0; k < `SCHED_DONE_DEPTH + 2; k++) begin
      send_done(core_id_t'($urandom_range(0, CORES - 1)));
    end
    repeat (10) @(negedge clk);
    assert (!ctrl_s_ready) else stop_run("control input ready while the done FIFO is full");
    drain_output("pkt_done");

    // Host command overtakes queued packet-done words
    for (int k = 0; k < 3; k++) send_done(core_id_t'($urandom_range(0, CORES - 1)));
    n = 0;
    #1;
    while (!ctrl_m_valid) begin
      @(negedge clk);
      #1;
      n++;
      if (n > TIMEOUT) stop_run("first packet-done word never reached the output");
    end
    @(negedge clk);
    host_cmd       = 4'($urandom);
    host_cmd_dest  = core_id_t'($urandom);
    host_cmd_data  = $urandom;
    host_cmd_valid = 1'b1;
    out_q.insert(1, {host_cmd_dest, host_cmd, host_cmd_data});
    n = 0;
    #1;
    while (!host_cmd_ready) begin
      @(negedge clk);
      #1;
      n++;
      if (n > TIMEOUT) stop_run("host command never accepted");
    end
    @(negedge clk);
    host_cmd_valid = 1'b0;
    #1;
    assert (!host_cmd_ready) else stop_run("host command ready while a command is held");
    drain_output("host_prio");
    repeat (5) @(negedge clk);
    assert (!ctrl_m_valid) else stop_run("unexpected extra control output message");

    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+hw
hw/sched_pkg.sv
hw/sched_if.sv
hw/sync_fifo.sv
hw/slot_keeper.sv
hw/slot_pool.sv
hw/ctrl_msg_decode.sv
hw/ctrl_out_mux.sv
hw/rx_desc_alloc.sv
hw/sched_top.sv
bench/tb_sched_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_sched_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
